// ==== Bender.yml ====
package:
  name: arcino_ex_block

sources:
  - hw/arcino_isa_pkg.sv
  - hw/arcino_ex_pkg.sv
  - hw/arcino_alu.sv
  - hw/arcino_multiplier.sv
  - hw/arcino_ex_result.sv
  - hw/arcino_ex_block.sv
  - target: simulation
    files:
      - sim/arcino_ex_block_tb.sv

// ==== all.f ====
hw/arcino_isa_pkg.sv
hw/arcino_ex_pkg.sv
hw/arcino_alu.sv
hw/arcino_multiplier.sv
hw/arcino_ex_result.sv
hw/arcino_ex_block.sv
sim/arcino_ex_block_tb.sv

// ==== hw/arcino_alu.sv ====
////////////////////////////////////////
// Combinational ALU of the execute block
// Arithmetic, logic, shifts and compares,
// plus branch decision and jump target
////////////////////////////////////////

`timescale 1ns/1ps

module arcino_alu (
  input  arcino_ex_pkg::alu_req_t alu_req_i,
  output arcino_ex_pkg::alu_rsp_t alu_rsp_o
);

  localparam int unsigned W = arcino_ex_pkg::XLEN;

  logic [W-1:0] op_a;
  logic [W-1:0] op_b;
  logic [4:0]   shamt;

  logic         adder_sub;
  logic [W-1:0] adder_op_b;
  logic [W:0]   adder_full;
  logic [W-1:0] sra_result;

  logic         is_equal;
  logic         is_lt;
  logic         is_ltu;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  assign shamt = op_b[4:0];

  ////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////

  // Subtract for SUB and every ordering compare
  always_comb begin
    case (alu_req_i.operator)
      arcino_isa_pkg::ALU_SUB,
      arcino_isa_pkg::ALU_SLT,
      arcino_isa_pkg::ALU_SLTU,
      arcino_isa_pkg::ALU_LT,
      arcino_isa_pkg::ALU_LTU,
      arcino_isa_pkg::ALU_GE,
      arcino_isa_pkg::ALU_GEU: adder_sub = 1'b1;
      default:                 adder_sub = 1'b0;
    endcase
  end

  // a - b as a + ~b + 1
  assign adder_op_b = adder_sub ? ~op_b : op_b;
  assign adder_full = {1'b0, op_a} + {1'b0, adder_op_b} + {{W{1'b0}}, adder_sub};

  ////////////////////////////////////////
  // Comparisons
  ////////////////////////////////////////

  assign is_equal = ~|(op_a ^ op_b);
  // No carry out of a - b means a below b
  assign is_ltu   = ~adder_full[W];
  // Differing signs decide directly, else the sign of the difference
  assign is_lt    = (op_a[W-1] ^ op_b[W-1]) ? op_a[W-1] : adder_full[W-1];

  always_comb begin
    case (alu_req_i.operator)
      arcino_isa_pkg::ALU_EQ:   alu_rsp_o.cmp_result = is_equal;
      arcino_isa_pkg::ALU_NE:   alu_rsp_o.cmp_result = ~is_equal;
      arcino_isa_pkg::ALU_SLT,
      arcino_isa_pkg::ALU_LT:   alu_rsp_o.cmp_result = is_lt;
      arcino_isa_pkg::ALU_SLTU,
      arcino_isa_pkg::ALU_LTU:  alu_rsp_o.cmp_result = is_ltu;
      arcino_isa_pkg::ALU_GE:   alu_rsp_o.cmp_result = ~is_lt;
      arcino_isa_pkg::ALU_GEU:  alu_rsp_o.cmp_result = ~is_ltu;
      default:                  alu_rsp_o.cmp_result = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  // Arithmetic shift with sign fill
  assign sra_result = $unsigned($signed(op_a) >>> shamt);

  always_comb begin
    case (alu_req_i.operator)
      arcino_isa_pkg::ALU_ADD,
      arcino_isa_pkg::ALU_SUB:  alu_rsp_o.result = adder_full[W-1:0];
      arcino_isa_pkg::ALU_XOR:  alu_rsp_o.result = op_a ^ op_b;
      arcino_isa_pkg::ALU_OR:   alu_rsp_o.result = op_a | op_b;
      arcino_isa_pkg::ALU_AND:  alu_rsp_o.result = op_a & op_b;
      arcino_isa_pkg::ALU_SLL:  alu_rsp_o.result = op_a << shamt;
      arcino_isa_pkg::ALU_SRL:  alu_rsp_o.result = op_a >> shamt;
      arcino_isa_pkg::ALU_SRA:  alu_rsp_o.result = sra_result;
      // Every compare returns 0 or 1
      default: alu_rsp_o.result = {{(W-1){1'b0}}, alu_rsp_o.cmp_result};
    endcase
  end

  assign alu_rsp_o.adder_result = adder_full[W-1:0];

endmodule

// ==== hw/arcino_ex_block.sv ====
////////////////////////////////////////
// Execute block top level
// ALU and multiplier side by side, joined
// by the result stage
// RV32M = 0 leaves the multiplier out
////////////////////////////////////////

`timescale 1ns/1ps

module arcino_ex_block #(
  parameter bit RV32M = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  arcino_ex_pkg::alu_req_t        alu_req_i,
  input  arcino_ex_pkg::md_req_t         md_req_i,
  output logic [arcino_ex_pkg::XLEN-1:0] regfile_wdata_o,
  output logic [arcino_ex_pkg::XLEN-1:0] jump_target_o,
  output logic                           branch_decision_o,
  output logic                           ex_ready_o
);

  arcino_ex_pkg::alu_rsp_t alu_rsp;
  arcino_ex_pkg::md_rsp_t  md_rsp;

  arcino_alu u_alu (
    .alu_req_i ( alu_req_i ),
    .alu_rsp_o ( alu_rsp   )
  );

  if (RV32M) begin : g_mult
    arcino_multiplier u_multiplier (
      .clk_i    ( clk_i    ),
      .rst_ni   ( rst_ni   ),
      .md_req_i ( md_req_i ),
      .md_rsp_o ( md_rsp   )
    );
  end else begin : g_no_mult
    // Always done, so a stray enable never stalls
    assign md_rsp.valid  = 1'b1;
    assign md_rsp.result = '0;
  end

  arcino_ex_result u_result (
    .md_en_i         ( md_req_i.en     ),
    .alu_rsp_i       ( alu_rsp         ),
    .md_rsp_i        ( md_rsp          ),
    .regfile_wdata_o ( regfile_wdata_o ),
    .ex_ready_o      ( ex_ready_o      )
  );

  // To fetch: jump target and branch decision
  assign jump_target_o     = alu_rsp.adder_result;
  assign branch_decision_o = alu_rsp.cmp_result;

endmodule

// ==== hw/arcino_ex_pkg.sv ====
////////////////////////////////////////
// Data width and request/response structs
// of the execute block
// Used on the ports of every execute module
////////////////////////////////////////

package arcino_ex_pkg;

  // Data path width
  parameter int unsigned XLEN = 32;

  ////////////////////////////////////////
  // ALU side
  ////////////////////////////////////////

  typedef struct packed {
    arcino_isa_pkg::alu_op_e operator;
    logic [XLEN-1:0]         operand_a;
    logic [XLEN-1:0]         operand_b;
  } alu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            cmp_result;
    // Sum of the shared adder, also the jump target
    logic [XLEN-1:0] adder_result;
  } alu_rsp_t;

  ////////////////////////////////////////
  // Multiplier side
  ////////////////////////////////////////

  typedef struct packed {
    logic                     en;
    arcino_isa_pkg::md_op_e   operator;
    arcino_isa_pkg::md_sign_t signed_mode;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
  } md_req_t;

  typedef struct packed {
    logic            valid;  // one-cycle done strobe
    logic [XLEN-1:0] result;
  } md_rsp_t;

endpackage

// ==== hw/arcino_ex_result.sv ====
////////////////////////////////////////
// Result stage of the execute block
// Picks the write-back word and drives the
// stall level toward the decode stage
////////////////////////////////////////

`timescale 1ns/1ps

module arcino_ex_result (
  input  logic                                md_en_i,
  input  arcino_ex_pkg::alu_rsp_t             alu_rsp_i,
  input  arcino_ex_pkg::md_rsp_t              md_rsp_i,
  output logic [arcino_ex_pkg::XLEN-1:0]      regfile_wdata_o,
  output logic                                ex_ready_o
);

  logic md_pending;

  // Multiply enabled but not finished yet
  assign md_pending = md_en_i & ~md_rsp_i.valid;

  ////////////////////////////////////////
  // Write-back select
  ////////////////////////////////////////

  always_comb begin
    if (md_en_i) begin
      regfile_wdata_o = md_rsp_i.result;
    end else begin
      regfile_wdata_o = alu_rsp_i.result;
    end
  end

  // Stall upstream while a multiply runs
  assign ex_ready_o = ~md_pending;

endmodule

// ==== hw/arcino_isa_pkg.sv ====
////////////////////////////////////////
// Operation encodings of the execute block
// Shared by the ALU, the multiplier and the testbench
// Refer to the types by scoped name
////////////////////////////////////////

package arcino_isa_pkg;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    // Arithmetic and logic
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    // Shifts
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    // Set less than
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    // Branch comparisons
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_LTU  = 5'd13,
    ALU_GE   = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  ////////////////////////////////////////
  // Multiplier operations
  ////////////////////////////////////////

  // Low or high word of the 64-bit product
  typedef enum logic {
    MD_OP_MULL = 1'b0,
    MD_OP_MULH = 1'b1
  } md_op_e;

  // Bit 0 marks operand a signed, bit 1 marks operand b signed
  // 00 MULHU, 01 MULHSU, 11 MULH
  typedef logic [1:0] md_sign_t;

endpackage

// ==== hw/arcino_multiplier.sv ====
////////////////////////////////////////
// Sequential RV32M multiplier
// Shift-add over 32 cycles on operand magnitudes,
// sign fixed in the done cycle
// Result valid for one cycle, 33 cycles after accept
////////////////////////////////////////

`timescale 1ns/1ps

module arcino_multiplier (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  arcino_ex_pkg::md_req_t md_req_i,
  output arcino_ex_pkg::md_rsp_t md_rsp_o
);

  localparam int unsigned W = arcino_ex_pkg::XLEN;

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_BUSY,
    MD_DONE
  } md_state_e;

  md_state_e state_q;
  logic [4:0] cnt_q;
  logic       accept;

  // Payload of the running multiply
  logic [2*W-1:0]         acc_q;
  logic [W-1:0]           mcand_q;
  logic                   neg_q;
  arcino_isa_pkg::md_op_e op_q;

  logic         a_neg;
  logic         b_neg;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;
  logic [W:0]   step_sum;
  logic [2*W-1:0] product;

  assign accept = (state_q == MD_IDLE) & md_req_i.en;

  // Magnitudes according to the signed mode
  assign a_neg = md_req_i.signed_mode[0] & md_req_i.operand_a[W-1];
  assign b_neg = md_req_i.signed_mode[1] & md_req_i.operand_b[W-1];
  assign a_mag = a_neg ? (~md_req_i.operand_a + 1'b1) : md_req_i.operand_a;
  assign b_mag = b_neg ? (~md_req_i.operand_b + 1'b1) : md_req_i.operand_b;

  // Add multiplicand to the upper half when the low bit is set
  assign step_sum = {1'b0, acc_q[2*W-1:W]} + (acc_q[0] ? {1'b0, mcand_q} : {(W+1){1'b0}});

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MD_IDLE: begin
          if (md_req_i.en) begin
            state_q <= MD_BUSY;
            cnt_q   <= '0;
          end
        end
        MD_BUSY: begin
          cnt_q <= cnt_q + 5'd1;
          if (cnt_q == 5'd31) begin
            state_q <= MD_DONE;
          end
        end
        // En is not looked at here
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_q   <= {{W{1'b0}}, b_mag};
      mcand_q <= a_mag;
      neg_q   <= a_neg ^ b_neg;
      op_q    <= md_req_i.operator;
    end else if (state_q == MD_BUSY) begin
      acc_q <= {step_sum, acc_q[W-1:1]};
    end
  end

  // Restore the sign of the product
  assign product = neg_q ? (~acc_q + 1'b1) : acc_q;

  assign md_rsp_o.valid  = (state_q == MD_DONE);
  assign md_rsp_o.result = (op_q == arcino_isa_pkg::MD_OP_MULH) ? product[2*W-1:W]
                                                                : product[W-1:0];

endmodule

// ==== sim/arcino_ex_block_tb.sv ====
////////////////////////////////////////
// Directed testbench of the execute block
// Runs ALU, branch and multiply tests against
// expected values from the ISA rules
// Stops at the first mismatch
////////////////////////////////////////

`timescale 1ns/1ps

module arcino_ex_block_tb;

  localparam int unsigned W               = arcino_ex_pkg::XLEN;
  localparam int unsigned CLK_PERIOD      = 10;
  localparam int unsigned NUM_OPS         = 400;
  localparam int unsigned MUL_WAIT_MAX    = 40;
  localparam int unsigned WATCHDOG_CYCLES = NUM_OPS * 40 + 200;

  logic                    clk_i;
  logic                    rst_ni;
  arcino_ex_pkg::alu_req_t alu_req;
  arcino_ex_pkg::md_req_t  md_req;
  logic [W-1:0]            regfile_wdata;
  logic [W-1:0]            jump_target;
  logic                    branch_decision;
  logic                    ex_ready;

  integer       seed = 32'h70148b91;
  logic [W-1:0] edge_vals [4] = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF};

  arcino_ex_block #(
    .RV32M ( 1'b1 )
  ) u_arcino_ex_block (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .alu_req_i         ( alu_req         ),
    .md_req_i          ( md_req          ),
    .regfile_wdata_o   ( regfile_wdata   ),
    .jump_target_o     ( jump_target     ),
    .branch_decision_o ( branch_decision ),
    .ex_ready_o        ( ex_ready        )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reporting and checks
  ////////////////////////////////////////

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [W-1:0] expected,
                            input logic [W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %0b actual %0b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // Drivers and reference
  ////////////////////////////////////////

  // Outputs are sampled at the falling edge
  task automatic apply_alu(input arcino_isa_pkg::alu_op_e op, input logic [W-1:0] a,
                           input logic [W-1:0] b);
    @(posedge clk_i);
    #1;
    alu_req.operator  = op;
    alu_req.operand_a = a;
    alu_req.operand_b = b;
    @(negedge clk_i);
  endtask

  // Holds en until ready is seen, leaves it high on return
  task automatic run_mul(input arcino_isa_pkg::md_op_e op, input arcino_isa_pkg::md_sign_t mode,
                         input logic [W-1:0] a, input logic [W-1:0] b,
                         output logic [W-1:0] result, output int low_cycles);
    int cycles;
    @(posedge clk_i);
    #1;
    md_req.en          = 1'b1;
    md_req.operator    = op;
    md_req.signed_mode = mode;
    md_req.operand_a   = a;
    md_req.operand_b   = b;
    cycles = 0;
    @(negedge clk_i);
    while (!ex_ready) begin
      cycles++;
      if (cycles > MUL_WAIT_MAX) begin
        $display("Multiply did not finish within %0d cycles", MUL_WAIT_MAX);
        stop_with_failure();
      end
      @(negedge clk_i);
    end
    result     = regfile_wdata;
    low_cycles = cycles;
  endtask

  task automatic release_mul();
    @(posedge clk_i);
    #1;
    md_req.en = 1'b0;
    @(negedge clk_i);
    check_bit("mul release ready", 1'b1, ex_ready);
  endtask

  // Product of the operands extended as the mode states
  function automatic logic [W-1:0] mul_expected(input arcino_isa_pkg::md_op_e op,
                                                input arcino_isa_pkg::md_sign_t mode,
                                                input logic [W-1:0] a, input logic [W-1:0] b);
    logic [2*W-1:0] ext_a;
    logic [2*W-1:0] ext_b;
    logic [2*W-1:0] prod;
    ext_a = mode[0] ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
    ext_b = mode[1] ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
    prod  = ext_a * ext_b;
    return (op == arcino_isa_pkg::MD_OP_MULH) ? prod[2*W-1:W] : prod[W-1:0];
  endfunction

  // Edge pairs first, then random pairs, then equal pairs
  task automatic pick_operands(input int p, output logic [W-1:0] a, output logic [W-1:0] b);
    if (p < 16) begin
      a = edge_vals[p / 4];
      b = edge_vals[p % 4];
    end else if (p < 24) begin
      a = $random(seed);
      b = $random(seed);
    end else begin
      a = $random(seed);
      b = a;
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_arith();
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      apply_alu(arcino_isa_pkg::ALU_ADD, a, b);
      check_word("arith ADD", a + b, regfile_wdata);
      check_bit("arith ready", 1'b1, ex_ready);
      apply_alu(arcino_isa_pkg::ALU_SUB, a, b);
      check_word("arith SUB", a - b, regfile_wdata);
      apply_alu(arcino_isa_pkg::ALU_XOR, a, b);
      check_word("arith XOR", a ^ b, regfile_wdata);
      apply_alu(arcino_isa_pkg::ALU_OR, a, b);
      check_word("arith OR", a | b, regfile_wdata);
      apply_alu(arcino_isa_pkg::ALU_AND, a, b);
      check_word("arith AND", a & b, regfile_wdata);
    end
  endtask

  task automatic test_shift_slt();
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] exp;
    for (int p = 0; p < 24; p++) begin
      pick_operands(p, a, b);
      apply_alu(arcino_isa_pkg::ALU_SLL, a, b);
      check_word("shift SLL", a << b[4:0], regfile_wdata);
      apply_alu(arcino_isa_pkg::ALU_SRL, a, b);
      check_word("shift SRL", a >> b[4:0], regfile_wdata);
      // Logical shift, then ones in the vacated top bits for a negative a
      exp = (a >> b[4:0]) | (a[W-1] ? ~({W{1'b1}} >> b[4:0]) : {W{1'b0}});
      apply_alu(arcino_isa_pkg::ALU_SRA, a, b);
      check_word("shift SRA", exp, regfile_wdata);
      exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      apply_alu(arcino_isa_pkg::ALU_SLT, a, b);
      check_word("set SLT", exp, regfile_wdata);
      exp = (a < b) ? 32'd1 : 32'd0;
      apply_alu(arcino_isa_pkg::ALU_SLTU, a, b);
      check_word("set SLTU", exp, regfile_wdata);
    end
  endtask

  task automatic test_branch();
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int p = 0; p < 28; p++) begin
      pick_operands(p, a, b);
      apply_alu(arcino_isa_pkg::ALU_EQ, a, b);
      check_bit("branch EQ", a == b, branch_decision);
      apply_alu(arcino_isa_pkg::ALU_NE, a, b);
      check_bit("branch NE", a != b, branch_decision);
      apply_alu(arcino_isa_pkg::ALU_LT, a, b);
      check_bit("branch LT", $signed(a) < $signed(b), branch_decision);
      apply_alu(arcino_isa_pkg::ALU_LTU, a, b);
      check_bit("branch LTU", a < b, branch_decision);
      apply_alu(arcino_isa_pkg::ALU_GE, a, b);
      check_bit("branch GE", $signed(a) >= $signed(b), branch_decision);
      apply_alu(arcino_isa_pkg::ALU_GEU, a, b);
      check_bit("branch GEU", a >= b, branch_decision);
      apply_alu(arcino_isa_pkg::ALU_ADD, a, b);
      check_word("jump target", a + b, jump_target);
    end
  endtask

  task automatic test_mul();
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] result;
    int           low;
    for (int m = 0; m < 4; m++) begin
      for (int o = 0; o < 2; o++) begin
        for (int k = 0; k < 3; k++) begin
          a = (k == 0) ? 32'h8000_0000 : $random(seed);
          b = (k == 0) ? 32'hFFFF_FFFF : $random(seed);
          run_mul(arcino_isa_pkg::md_op_e'(o), arcino_isa_pkg::md_sign_t'(m), a, b, result, low);
          check_word("mul result",
                     mul_expected(arcino_isa_pkg::md_op_e'(o), arcino_isa_pkg::md_sign_t'(m), a, b),
                     result);
          release_mul();
        end
      end
    end
  endtask

  task automatic test_stall();
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] result;
    int           low;
    @(negedge clk_i);
    check_bit("stall idle ready", 1'b1, ex_ready);
    // Two multiplies back to back with en held
    for (int i = 0; i < 2; i++) begin
      a = $random(seed);
      b = $random(seed);
      run_mul(arcino_isa_pkg::MD_OP_MULL, 2'b11, a, b, result, low);
      if (low < 32) begin
        $display("Ready rose after only %0d stall cycles", low);
        stop_with_failure();
      end
      check_word("stall mul result", mul_expected(arcino_isa_pkg::MD_OP_MULL, 2'b11, a, b),
                 result);
    end
    release_mul();
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    alu_req = '0;
    md_req  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_stall();
    test_arith();
    test_shift_slt();
    test_branch();
    test_mul();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

endmodule
